// File: hw/rv_exe_consts.svh
`ifndef RV_EXE_CONSTS_SVH
`define RV_EXE_CONSTS_SVH

// data path widths
`define GPR_WIDTH       32
`define SYS_ADDR_SPACE  32
`define GPR_ADDR_SPACE  5
`define IMM_WIDTH       32
`define INST_ID_LEN     10
`define FUNCT3_WIDTH    3

// instruction ids, {funct3, index}
`define ADDI_ID    {3'b000, 7'd1}
`define SLTI_ID    {3'b010, 7'd2}
`define SLTIU_ID   {3'b011, 7'd3}
`define XORI_ID    {3'b100, 7'd4}
`define ORI_ID     {3'b110, 7'd5}
`define ANDI_ID    {3'b111, 7'd6}
`define SLLI_ID    {3'b001, 7'd7}
`define SRLI_ID    {3'b101, 7'd8}
`define SRAI_ID    {3'b101, 7'd9}
`define ADD_ID     {3'b000, 7'd10}
`define SUB_ID     {3'b000, 7'd11}
`define SLL_ID     {3'b001, 7'd12}
`define SLT_ID     {3'b010, 7'd13}
`define SLTU_ID    {3'b011, 7'd14}
`define XOR_ID     {3'b100, 7'd15}
`define SRL_ID     {3'b101, 7'd16}
`define SRA_ID     {3'b101, 7'd17}
`define OR_ID      {3'b110, 7'd18}
`define AND_ID     {3'b111, 7'd19}
`define LUI_ID     {3'b000, 7'd20}
`define AUIPC_ID   {3'b000, 7'd21}
`define JAL_ID     {3'b000, 7'd22}
`define JALR_ID    {3'b000, 7'd23}
`define LB_ID      {3'b000, 7'd24}
`define LH_ID      {3'b001, 7'd25}
`define LW_ID      {3'b010, 7'd26}
`define LBU_ID     {3'b100, 7'd27}
`define LHU_ID     {3'b101, 7'd28}
`define SB_ID      {3'b000, 7'd29}
`define SH_ID      {3'b001, 7'd30}
`define SW_ID      {3'b010, 7'd31}
`define MUL_ID     {3'b000, 7'd32}
`define MULH_ID    {3'b001, 7'd33}
`define MULHSU_ID  {3'b010, 7'd34}
`define MULHU_ID   {3'b011, 7'd35}
`define DIV_ID     {3'b100, 7'd36}
`define DIVU_ID    {3'b101, 7'd37}
`define REM_ID     {3'b110, 7'd38}
`define REMU_ID    {3'b111, 7'd39}

// forward select, {rs2 enable, rs1 enable}
`define FWD_NONE   2'b00
`define FWD_RS1    2'b01
`define FWD_RS2    2'b10
`define FWD_BOTH   2'b11

// M unit cycles from start to ready
`define MUL_LATENCY  2
`define DIV_LATENCY  33

`endif

// File: hw/rv_exe_pkg.sv
`include "rv_exe_consts.svh"

package rv_exe_pkg;

    typedef logic [`GPR_WIDTH-1:0]      gpr_t;
    typedef logic [`SYS_ADDR_SPACE-1:0] pc_t;
    typedef logic [`GPR_ADDR_SPACE-1:0] reg_addr_t;
    typedef logic [`IMM_WIDTH-1:0]      imm_t;
    typedef logic [`INST_ID_LEN-1:0]    inst_id_t;
    typedef logic [`FUNCT3_WIDTH-1:0]   funct3_t;

    // ID/EXE bundle
    typedef struct packed {
        pc_t       pc;
        reg_addr_t rd_addr;
        logic      rd_we;
        logic      mem_re;
        logic      mem_we;
        inst_id_t  instr_id;
        gpr_t      rs1_val;
        gpr_t      rs2_val;
        imm_t      imm;
    } exe_in_t;

    // from the forwarding unit
    typedef struct packed {
        gpr_t rs1_val;
        gpr_t rs2_val;
        logic rs1_we;
        logic rs2_we;
    } fwd_t;

    // EXE/WB bundle
    typedef struct packed {
        gpr_t      alu_val;
        reg_addr_t rd_addr;
        logic      rd_we;
        gpr_t      rs2_val;
        logic      mem_re;
        logic      mem_we;
        funct3_t   mem_mode;
    } exe_out_t;

    typedef enum logic [1:0] {
        M_IDLE,
        M_MUL,
        M_DIV,
        M_DONE
    } m_state_t;

endpackage

// File: hw/exe_alu.sv
`include "rv_exe_consts.svh"

module exe_alu (
    input  rv_exe_pkg::inst_id_t instr_id_i,
    input  rv_exe_pkg::pc_t      pc_i,
    input  rv_exe_pkg::gpr_t     rs1_i,
    input  rv_exe_pkg::gpr_t     rs2_i,
    input  rv_exe_pkg::imm_t     imm_i,
    output rv_exe_pkg::gpr_t     result_o
);
    import rv_exe_pkg::*;

    gpr_t       sum_imm;
    logic [4:0] shamt_rs2;
    logic [4:0] shamt_imm;

    // shared by addi and the load/store address
    assign sum_imm   = rs1_i + imm_i;
    assign shamt_rs2 = rs2_i[4:0];
    assign shamt_imm = imm_i[4:0];

    always_comb begin
        case (instr_id_i)
            `ADDI_ID, `LB_ID, `LH_ID, `LW_ID, `LBU_ID, `LHU_ID,
            `SB_ID, `SH_ID, `SW_ID: begin
                result_o = sum_imm;
            end
            `SLTI_ID: begin
                result_o = gpr_t'($signed(rs1_i) < $signed(imm_i));
            end
            `SLTIU_ID: begin
                result_o = gpr_t'(rs1_i < imm_i);
            end
            `XORI_ID: begin
                result_o = rs1_i ^ imm_i;
            end
            `ORI_ID: begin
                result_o = rs1_i | imm_i;
            end
            `ANDI_ID: begin
                result_o = rs1_i & imm_i;
            end
            `SLLI_ID: begin
                result_o = rs1_i << shamt_imm;
            end
            `SRLI_ID: begin
                result_o = rs1_i >> shamt_imm;
            end
            `SRAI_ID: begin
                result_o = gpr_t'($signed(rs1_i) >>> shamt_imm);
            end
            `ADD_ID: begin
                result_o = rs1_i + rs2_i;
            end
            `SUB_ID: begin
                result_o = rs1_i - rs2_i;
            end
            `SLL_ID: begin
                result_o = rs1_i << shamt_rs2;
            end
            `SLT_ID: begin
                result_o = gpr_t'($signed(rs1_i) < $signed(rs2_i));
            end
            `SLTU_ID: begin
                result_o = gpr_t'(rs1_i < rs2_i);
            end
            `XOR_ID: begin
                result_o = rs1_i ^ rs2_i;
            end
            `SRL_ID: begin
                result_o = rs1_i >> shamt_rs2;
            end
            `SRA_ID: begin
                result_o = gpr_t'($signed(rs1_i) >>> shamt_rs2);
            end
            `OR_ID: begin
                result_o = rs1_i | rs2_i;
            end
            `AND_ID: begin
                result_o = rs1_i & rs2_i;
            end
            `LUI_ID: begin
                result_o = imm_i;
            end
            `AUIPC_ID: begin
                result_o = pc_i + imm_i;
            end
            // link address
            `JAL_ID, `JALR_ID: begin
                result_o = pc_i + `SYS_ADDR_SPACE'd4;
            end
            default: begin
                result_o = '0;
            end
        endcase
    end

endmodule

// File: hw/div_iter.sv
`include "rv_exe_consts.svh"

module div_iter (
    input  logic             clk_i,
    input  logic             rst_i,
    input  logic             start_i,
    input  rv_exe_pkg::gpr_t dividend_i,
    input  rv_exe_pkg::gpr_t divisor_i,
    output logic             done_o,
    output rv_exe_pkg::gpr_t quotient_o,
    output rv_exe_pkg::gpr_t remainder_o
);
    import rv_exe_pkg::*;

    localparam logic [5:0] LAST_STEP = 6'(`GPR_WIDTH - 1);

    logic [5:0]          cnt_q;
    logic                busy_q;
    logic                done_q;
    gpr_t                rem_q;
    gpr_t                quo_q;
    gpr_t                dvs_q;
    gpr_t                src_rem;
    gpr_t                src_quo;
    gpr_t                src_dvs;
    logic [`GPR_WIDTH:0] trial;
    logic [`GPR_WIDTH:0] diff;
    gpr_t                step_rem;
    gpr_t                step_quo;

    // start cycle runs the first step straight from the inputs
    always_comb begin
        src_rem = start_i ? '0 : rem_q;
        src_quo = start_i ? dividend_i : quo_q;
        src_dvs = start_i ? divisor_i : dvs_q;
        trial   = {src_rem, src_quo[`GPR_WIDTH-1]};
        diff    = trial - {1'b0, src_dvs};
        if (diff[`GPR_WIDTH]) begin
            // borrow, keep the shifted remainder
            step_rem = trial[`GPR_WIDTH-1:0];
            step_quo = {src_quo[`GPR_WIDTH-2:0], 1'b0};
        end else begin
            step_rem = diff[`GPR_WIDTH-1:0];
            step_quo = {src_quo[`GPR_WIDTH-2:0], 1'b1};
        end
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            busy_q <= 1'b0;
            cnt_q  <= '0;
            done_q <= 1'b0;
        end else begin
            done_q <= 1'b0;
            if (start_i) begin
                busy_q <= 1'b1;
                cnt_q  <= 6'd1;
            end else if (busy_q) begin
                cnt_q <= cnt_q + 6'd1;
                if (cnt_q == LAST_STEP) begin
                    busy_q <= 1'b0;
                    done_q <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (start_i || busy_q) begin
            rem_q <= step_rem;
            quo_q <= step_quo;
        end
        if (start_i) begin
            dvs_q <= divisor_i;
        end
    end

    assign done_o      = done_q;
    assign quotient_o  = quo_q;
    assign remainder_o = rem_q;

    a_no_restart: assert property (@(posedge clk_i) disable iff (rst_i)
        start_i |-> !busy_q);

    // single done pulse at the end of the step sequence
    a_done_pulse: assert property (@(posedge clk_i) disable iff (rst_i)
        $rose(busy_q) |-> ##(`GPR_WIDTH - 1) (done_o ##1 !done_o));

endmodule

// File: hw/m_unit.sv
`include "rv_exe_consts.svh"

module m_unit (
    input  logic                 clk_i,
    input  logic                 rst_i,
    input  logic                 ce_i,
    input  rv_exe_pkg::inst_id_t instr_id_i,
    input  rv_exe_pkg::gpr_t     rs1_i,
    input  rv_exe_pkg::gpr_t     rs2_i,
    output logic                 ready_o,
    output rv_exe_pkg::gpr_t     result_o
);
    import rv_exe_pkg::*;

    localparam int         LAT_W    = 6;
    localparam logic [5:0] MUL_WAIT = LAT_W'(`MUL_LATENCY - 2);
    localparam logic [5:0] DIV_WAIT = LAT_W'(`DIV_LATENCY - 2);

    m_state_t                        state_q;
    logic [LAT_W-1:0]                lat_q;
    gpr_t                            result_q;
    funct3_t                         f3;
    logic                            launch;
    logic                            is_div;
    logic signed [`GPR_WIDTH:0]      mul_a;
    logic signed [`GPR_WIDTH:0]      mul_b;
    logic signed [2*`GPR_WIDTH+1:0]  product;
    gpr_t                            mul_res;
    logic                            div_signed;
    logic                            rs1_neg;
    logic                            rs2_neg;
    logic                            div_zero;
    gpr_t                            dvd_mag;
    gpr_t                            dvs_mag;
    logic                            div_done;
    gpr_t                            quo_u;
    gpr_t                            rem_u;
    gpr_t                            div_res;

    // funct3 field selects the M variant
    assign f3     = instr_id_i[`INST_ID_LEN-1 -: `FUNCT3_WIDTH];
    assign is_div = f3[2];
    assign launch = ce_i && (state_q == M_IDLE);

    // 33-bit extension covers mulh, mulhsu and mulhu alike
    assign mul_a   = {(f3 == 3'b001 || f3 == 3'b010) & rs1_i[`GPR_WIDTH-1], rs1_i};
    assign mul_b   = {(f3 == 3'b001) & rs2_i[`GPR_WIDTH-1], rs2_i};
    assign product = mul_a * mul_b;
    assign mul_res = (f3 == 3'b000) ? product[`GPR_WIDTH-1:0]
                                    : product[2*`GPR_WIDTH-1:`GPR_WIDTH];

    assign div_signed = ~f3[0];
    assign rs1_neg    = div_signed & rs1_i[`GPR_WIDTH-1];
    assign rs2_neg    = div_signed & rs2_i[`GPR_WIDTH-1];
    assign div_zero   = (rs2_i == '0);
    assign dvd_mag    = rs1_neg ? -rs1_i : rs1_i;
    // dummy divisor on zero keeps the step count uniform
    assign dvs_mag    = div_zero ? gpr_t'(1) : (rs2_neg ? -rs2_i : rs2_i);

    div_iter u_div (
        .clk_i       (clk_i),
        .rst_i       (rst_i),
        .start_i     (launch && is_div),
        .dividend_i  (dvd_mag),
        .divisor_i   (dvs_mag),
        .done_o      (div_done),
        .quotient_o  (quo_u),
        .remainder_o (rem_u)
    );

    // min by -1 falls out of the magnitude path
    always_comb begin
        if (div_zero) begin
            div_res = f3[1] ? rs1_i : '1;
        end else if (f3[1]) begin
            div_res = rs1_neg ? -rem_u : rem_u;
        end else begin
            div_res = (rs1_neg ^ rs2_neg) ? -quo_u : quo_u;
        end
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            state_q <= M_IDLE;
            lat_q   <= '0;
        end else begin
            case (state_q)
                M_IDLE: begin
                    if (launch) begin
                        state_q <= is_div ? M_DIV : M_MUL;
                        lat_q   <= is_div ? DIV_WAIT : MUL_WAIT;
                    end
                end
                M_MUL: begin
                    if (lat_q == '0) begin
                        state_q <= M_DONE;
                    end else begin
                        lat_q <= lat_q - 1'b1;
                    end
                end
                M_DIV: begin
                    if (lat_q != '0) begin
                        lat_q <= lat_q - 1'b1;
                    end
                    if (div_done) begin
                        state_q <= M_DONE;
                    end
                end
                default: begin
                    state_q <= M_IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge clk_i) begin
        if (launch && !is_div) begin
            result_q <= mul_res;
        end else if (state_q == M_DIV && div_done) begin
            result_q <= div_res;
        end
    end

    assign ready_o  = (state_q == M_DONE) || (state_q == M_IDLE && !ce_i);
    assign result_o = result_q;

    // ready_o comes back exactly when the latency has run out
    a_mul_ready: assert property (@(posedge clk_i) disable iff (rst_i)
        (launch && !is_div) |-> ##(`MUL_LATENCY) $rose(ready_o));

    a_div_ready: assert property (@(posedge clk_i) disable iff (rst_i)
        (launch && is_div) |-> ##(`DIV_LATENCY) $rose(ready_o));

    a_id_hold: assert property (@(posedge clk_i) disable iff (rst_i)
        (state_q == M_MUL || state_q == M_DIV) |-> $stable(instr_id_i));

    // divider finishes exactly when the latency budget runs out
    a_div_align: assert property (@(posedge clk_i) disable iff (rst_i)
        (state_q == M_DIV && div_done) |-> (lat_q == '0));

endmodule

// File: hw/exe_stage.sv
`include "rv_exe_consts.svh"

module exe_stage (
    input  logic                 clk_i,
    input  logic                 rst_i,
    input  rv_exe_pkg::exe_in_t  ex_i,
    input  rv_exe_pkg::fwd_t     fwd_i,
    output rv_exe_pkg::exe_out_t ex_o,
    output logic                 ready_o
);
    import rv_exe_pkg::*;

    logic [1:0] fwd_sel;
    gpr_t       rs1_sel;
    gpr_t       rs2_sel;
    gpr_t       alu_res;
    gpr_t       m_res;
    logic       m_ce;

    assign fwd_sel = {fwd_i.rs2_we, fwd_i.rs1_we};

    always_comb begin
        case (fwd_sel)
            `FWD_RS1: begin
                rs1_sel = fwd_i.rs1_val;
                rs2_sel = ex_i.rs2_val;
            end
            `FWD_RS2: begin
                rs1_sel = ex_i.rs1_val;
                rs2_sel = fwd_i.rs2_val;
            end
            `FWD_BOTH: begin
                rs1_sel = fwd_i.rs1_val;
                rs2_sel = fwd_i.rs2_val;
            end
            default: begin
                rs1_sel = ex_i.rs1_val;
                rs2_sel = ex_i.rs2_val;
            end
        endcase
    end

    // M class goes to the multi-cycle unit
    assign m_ce = ex_i.instr_id inside {`MUL_ID, `MULH_ID, `MULHSU_ID, `MULHU_ID,
                                        `DIV_ID, `DIVU_ID, `REM_ID, `REMU_ID};

    exe_alu u_alu (
        .instr_id_i (ex_i.instr_id),
        .pc_i       (ex_i.pc),
        .rs1_i      (rs1_sel),
        .rs2_i      (rs2_sel),
        .imm_i      (ex_i.imm),
        .result_o   (alu_res)
    );

    m_unit u_m_unit (
        .clk_i      (clk_i),
        .rst_i      (rst_i),
        .ce_i       (m_ce),
        .instr_id_i (ex_i.instr_id),
        .rs1_i      (rs1_sel),
        .rs2_i      (rs2_sel),
        .ready_o    (ready_o),
        .result_o   (m_res)
    );

    always_comb begin
        ex_o.alu_val  = m_ce ? m_res : alu_res;
        ex_o.rd_addr  = ex_i.rd_addr;
        ex_o.rd_we    = ex_i.rd_we;
        ex_o.rs2_val  = rs2_sel;
        ex_o.mem_re   = ex_i.mem_re;
        ex_o.mem_we   = ex_i.mem_we;
        // funct3 doubles as the memory access mode
        ex_o.mem_mode = ex_i.instr_id[`INST_ID_LEN-1 -: `FUNCT3_WIDTH];
    end

    // single-cycle ops never stall the pipeline
    a_no_stall: assert property (@(posedge clk_i) disable iff (rst_i)
        !m_ce |-> ready_o);

endmodule

// File: test/exe_stage_tb.sv
`include "rv_exe_consts.svh"

module exe_stage_tb;
    import rv_exe_pkg::*;

    localparam int RESET_CYCLES = 16;
    localparam int N_EDGE = 5;
    localparam int N_VALS = 12;
    localparam int N_DIV_OPS = 4 * (N_VALS + 2) + 6;
    localparam int CYCLE_LIMIT = RESET_CYCLES + (9 + 10 + 4 + 12 + 2) * N_VALS
                                 + 4 * N_VALS * (`MUL_LATENCY + 2)
                                 + N_DIV_OPS * (`DIV_LATENCY + 2) + 8;
    localparam gpr_t SIGN_BIT = 32'h8000_0000;

    logic     clk;
    logic     rst;
    exe_in_t  ex_in;
    fwd_t     fwd;
    exe_out_t ex_out;
    logic     ready;

    integer seed;
    int     errors;
    int     checks;
    int     tests;
    int     failed_tests;
    int     err_mark;
    int     cycle_cnt = 0;
    logic   m_in_done;

    exe_stage UUT (
        .clk_i   (clk),
        .rst_i   (rst),
        .ex_i    (ex_in),
        .fwd_i   (fwd),
        .ex_o    (ex_out),
        .ready_o (ready)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt == CYCLE_LIMIT) begin
            $display("timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
            $display("TESTS FAILED");
            $finish;
        end
    end

    function automatic gpr_t sext12(input logic [11:0] v);
        sext12 = {{20{v[11]}}, v};
    endfunction

    function automatic gpr_t edge_word(input int k);
        case (k)
            0: edge_word = 32'h0000_0000;
            1: edge_word = 32'h0000_0001;
            2: edge_word = 32'h7fff_ffff;
            3: edge_word = 32'h8000_0000;
            default: edge_word = 32'hffff_ffff;
        endcase
    endfunction

    // RISC-V reference behaviour for every instruction ID
    function automatic gpr_t expected_result(input inst_id_t id, input pc_t pc,
                                             input gpr_t a, input gpr_t b, input imm_t imm);
        logic [63:0] prod;
        int          sa;
        int          sb;
        sa = a;
        sb = b;
        prod = '0;
        case (id)
            `ADDI_ID, `LB_ID, `LH_ID, `LW_ID, `LBU_ID, `LHU_ID,
            `SB_ID, `SH_ID, `SW_ID: expected_result = a + imm;
            `SLTI_ID:  expected_result = {31'b0, (a ^ SIGN_BIT) < (imm ^ SIGN_BIT)};
            `SLTIU_ID: expected_result = {31'b0, a < imm};
            `XORI_ID:  expected_result = a ^ imm;
            `ORI_ID:   expected_result = a | imm;
            `ANDI_ID:  expected_result = a & imm;
            `SLLI_ID:  expected_result = a << imm[4:0];
            `SRLI_ID:  expected_result = a >> imm[4:0];
            `SRAI_ID:  expected_result = (a >> imm[4:0])
                                         | ({32{a[31]}} & ~(32'hffff_ffff >> imm[4:0]));
            `ADD_ID:   expected_result = a + b;
            `SUB_ID:   expected_result = a - b;
            `SLL_ID:   expected_result = a << b[4:0];
            `SLT_ID:   expected_result = {31'b0, (a ^ SIGN_BIT) < (b ^ SIGN_BIT)};
            `SLTU_ID:  expected_result = {31'b0, a < b};
            `XOR_ID:   expected_result = a ^ b;
            `SRL_ID:   expected_result = a >> b[4:0];
            `SRA_ID:   expected_result = (a >> b[4:0])
                                         | ({32{a[31]}} & ~(32'hffff_ffff >> b[4:0]));
            `OR_ID:    expected_result = a | b;
            `AND_ID:   expected_result = a & b;
            `LUI_ID:   expected_result = imm;
            `AUIPC_ID: expected_result = pc + imm;
            `JAL_ID, `JALR_ID: expected_result = pc + 32'd4;
            `MUL_ID: begin
                prod = {32'b0, a} * {32'b0, b};
                expected_result = prod[31:0];
            end
            `MULH_ID: begin
                prod = {{32{a[31]}}, a} * {{32{b[31]}}, b};
                expected_result = prod[63:32];
            end
            `MULHSU_ID: begin
                prod = {{32{a[31]}}, a} * {32'b0, b};
                expected_result = prod[63:32];
            end
            `MULHU_ID: begin
                prod = {32'b0, a} * {32'b0, b};
                expected_result = prod[63:32];
            end
            `DIV_ID: begin
                if (b == '0) expected_result = '1;
                else if (a == SIGN_BIT && b == '1) expected_result = a;
                else expected_result = sa / sb;
            end
            `REM_ID: begin
                if (b == '0) expected_result = a;
                else if (a == SIGN_BIT && b == '1) expected_result = '0;
                else expected_result = sa % sb;
            end
            `DIVU_ID: expected_result = (b == '0) ? '1 : a / b;
            `REMU_ID: expected_result = (b == '0) ? a : a % b;
            default:  expected_result = '0;
        endcase
    endfunction

    task automatic check_word(input string what, input gpr_t got, input gpr_t want);
        checks++;
        if (got !== want) begin
            errors++;
            $display("error at %0t: %s result %h expected %h", $time, what, got, want);
        end
    endtask

    task automatic check_out(input string what, input exe_out_t got, input exe_out_t want);
        checks++;
        if (got !== want) begin
            errors++;
            $display("error at %0t: %s ex_o %h expected %h", $time, what, got, want);
        end
    endtask

    task automatic check_ready(input string what, input logic got, input logic want);
        checks++;
        if (got !== want) begin
            errors++;
            $display("error at %0t: %s ready_o %b expected %b", $time, what, got, want);
        end
    endtask

    task automatic pick_operands(input int k, output gpr_t a, output gpr_t b);
        if (k < N_EDGE) begin
            a = edge_word(k);
            b = edge_word((k + 2) % N_EDGE);
        end else begin
            a = $random(seed);
            b = $random(seed);
        end
    endtask

    task automatic drive_inputs(input inst_id_t id, input gpr_t a, input gpr_t b,
                                input imm_t imm, input logic [1:0] fsel);
        gpr_t rnd;
        rnd = $random(seed);
        ex_in.pc       = $random(seed);
        ex_in.rd_addr  = rnd[4:0];
        ex_in.rd_we    = rnd[5];
        ex_in.mem_re   = rnd[6];
        ex_in.mem_we   = rnd[7];
        ex_in.instr_id = id;
        ex_in.imm      = imm;
        fwd.rs1_we     = fsel[0];
        fwd.rs2_we     = fsel[1];
        // the source that is not selected carries a decoy
        ex_in.rs1_val  = fsel[0] ? ~a : a;
        fwd.rs1_val    = fsel[0] ? a : ~a;
        ex_in.rs2_val  = fsel[1] ? ~b : b;
        fwd.rs2_val    = fsel[1] ? b : ~b;
    endtask

    task automatic apply_op(input inst_id_t id, input gpr_t a, input gpr_t b,
                            input imm_t imm, input logic [1:0] fsel);
        exe_out_t want;
        @(negedge clk);
        drive_inputs(id, a, b, imm, fsel);
        want.alu_val  = expected_result(id, ex_in.pc, a, b, imm);
        want.rd_addr  = ex_in.rd_addr;
        want.rd_we    = ex_in.rd_we;
        want.rs2_val  = b;
        want.mem_re   = ex_in.mem_re;
        want.mem_we   = ex_in.mem_we;
        want.mem_mode = id[9:7];
        #2;
        check_out($sformatf("op %h", id), ex_out, want);
        check_ready($sformatf("op %h", id), ready, 1'b1);
        m_in_done = 1'b0;
    endtask

    task automatic apply_m(input inst_id_t id, input gpr_t a, input gpr_t b);
        gpr_t     rnd;
        int       cycles;
        int       want;
        m_state_t st;
        rnd = $random(seed);
        want = (id inside {`DIV_ID, `DIVU_ID, `REM_ID, `REMU_ID}) ? `DIV_LATENCY
                                                                  : `MUL_LATENCY;
        @(negedge clk);
        drive_inputs(id, a, b, '0, rnd[1:0]);
        #2;
        // previous M op holds ready_o for one more cycle
        if (m_in_done) begin
            check_ready($sformatf("m op %h done cycle", id), ready, 1'b1);
            @(posedge clk);
            #2;
        end
        check_ready($sformatf("m op %h start", id), ready, 1'b0);
        cycles = 0;
        while (!ready && cycles <= `DIV_LATENCY + 2) begin
            @(posedge clk);
            #2;
            cycles++;
        end
        if (cycles != want) begin
            st = UUT.u_m_unit.state_q;
            errors++;
            $display("M op %h finished after %0d cycles instead of %0d, m_unit in %s",
                     id, cycles, want, st.name());
        end
        check_word($sformatf("m op %h", id), ex_out.alu_val,
                   expected_result(id, ex_in.pc, a, b, '0));
        m_in_done = 1'b1;
    endtask

    task automatic finish_test(input string name);
        tests++;
        if (errors == err_mark) begin
            $display("%-14s ok", name);
        end else begin
            failed_tests++;
            $display("%-14s %0d errors", name, errors - err_mark);
        end
        err_mark = errors;
    endtask

    task automatic imm_ops();
        inst_id_t ops [9];
        gpr_t     a;
        gpr_t     b;
        ops = '{`ADDI_ID, `SLTI_ID, `SLTIU_ID, `XORI_ID, `ORI_ID, `ANDI_ID,
                `SLLI_ID, `SRLI_ID, `SRAI_ID};
        foreach (ops[i]) begin
            for (int k = 0; k < N_VALS; k++) begin
                pick_operands(k, a, b);
                apply_op(ops[i], a, b, sext12(b[11:0]), `FWD_NONE);
            end
        end
        finish_test("imm_ops");
    endtask

    task automatic reg_ops();
        inst_id_t ops [10];
        gpr_t     a;
        gpr_t     b;
        ops = '{`ADD_ID, `SUB_ID, `SLL_ID, `SLT_ID, `SLTU_ID, `XOR_ID,
                `SRL_ID, `SRA_ID, `OR_ID, `AND_ID};
        foreach (ops[i]) begin
            for (int k = 0; k < N_VALS; k++) begin
                pick_operands(k, a, b);
                apply_op(ops[i], a, b, '0, `FWD_NONE);
            end
        end
        finish_test("reg_ops");
    endtask

    task automatic forwarding();
        gpr_t a;
        gpr_t b;
        for (int f = 0; f < 4; f++) begin
            for (int k = 0; k < N_VALS; k++) begin
                pick_operands(k, a, b);
                apply_op(k[0] ? `SUB_ID : `SLT_ID, a, b, '0, 2'(f));
            end
        end
        finish_test("forwarding");
    endtask

    task automatic addr_and_link();
        inst_id_t ops [12];
        gpr_t     a;
        gpr_t     b;
        imm_t     imm;
        ops = '{`LUI_ID, `AUIPC_ID, `JAL_ID, `JALR_ID, `LB_ID, `LH_ID, `LW_ID,
                `LBU_ID, `LHU_ID, `SB_ID, `SH_ID, `SW_ID};
        foreach (ops[i]) begin
            for (int k = 0; k < N_VALS; k++) begin
                pick_operands(k, a, b);
                if (ops[i] == `LUI_ID || ops[i] == `AUIPC_ID) begin
                    imm = {b[31:12], 12'b0};
                end else begin
                    imm = sext12(b[11:0]);
                end
                apply_op(ops[i], a, b, imm, 2'($random(seed)));
            end
        end
        finish_test("addr_and_link");
    endtask

    task automatic mul_family();
        inst_id_t ops [4];
        gpr_t     a;
        gpr_t     b;
        ops = '{`MUL_ID, `MULH_ID, `MULHSU_ID, `MULHU_ID};
        foreach (ops[i]) begin
            for (int k = 0; k < N_VALS; k++) begin
                pick_operands(k, a, b);
                apply_m(ops[i], a, b);
            end
        end
        finish_test("mul_family");
    endtask

    task automatic div_family();
        inst_id_t ops [4];
        gpr_t     a;
        gpr_t     b;
        ops = '{`DIV_ID, `DIVU_ID, `REM_ID, `REMU_ID};
        foreach (ops[i]) begin
            for (int k = 0; k < N_VALS; k++) begin
                pick_operands(k, a, b);
                apply_m(ops[i], a, b);
            end
            // divide by zero and most negative by minus one
            apply_m(ops[i], $random(seed), '0);
            apply_m(ops[i], SIGN_BIT, 32'hffff_ffff);
        end
        finish_test("div_family");
    endtask

    task automatic back_to_back();
        gpr_t a;
        gpr_t b;
        a = $random(seed);
        b = $random(seed);
        apply_m(`MULH_ID, a, b);
        apply_m(`DIVU_ID, a, b);
        apply_m(`REM_ID, b, a);
        apply_m(`REM_ID, b, a);
        apply_op(`ADD_ID, a, b, '0, `FWD_BOTH);
        apply_m(`MUL_ID, a, b);
        apply_m(`DIV_ID, a, 32'hffff_fff9);
        finish_test("back_to_back");
    endtask

    initial begin
        seed = 32'hee1a_6892;
        errors = 0;
        checks = 0;
        tests = 0;
        failed_tests = 0;
        err_mark = 0;
        m_in_done = 1'b0;
        rst = 1'b1;
        ex_in = '0;
        fwd = '0;
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        imm_ops();
        reg_ops();
        forwarding();
        addr_and_link();
        mul_family();
        div_family();
        back_to_back();

        @(negedge clk);
        ex_in = '0;
        fwd = '0;
        $display("tests %0d, failed %0d, checks %0d, errors %0d",
                 tests, failed_tests, checks, errors);
        if (errors == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

// File: sim.f
+incdir+hw
hw/rv_exe_pkg.sv
hw/exe_alu.sv
hw/div_iter.sv
hw/m_unit.sv
hw/exe_stage.sv
test/exe_stage_tb.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -Wno-fatal
TOP       := exe_stage_tb
FILELIST  := sim.f
OBJ_DIR   := obj_dir
SIM_BIN   := $(OBJ_DIR)/V$(TOP)

SOURCES := $(shell grep -v '^+' $(FILELIST)) hw/rv_exe_consts.svh

.PHONY: all run clean

all: $(SIM_BIN)

# rebuilt only when a source or the file list changes
$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR) -o V$(TOP)

run: $(SIM_BIN)
	@out="$$(./$(SIM_BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "TESTS PASSED"

clean:
	rm -rf $(OBJ_DIR)
